// ==== bench/cfg_testdata.txt ====
# test op reg size uns lane data expect; size 0 byte 1 half 2 word; reg, data, expect in hex
# op W store, R load and compare, P poll until idle, S push that must stall while full
1 R 3 2 0 0 00000000 00000000
1 R 4 2 0 0 00000000 00000000
1 R 0 2 0 0 00000000 00000000
2 W 1 0 0 0 00000011 00000000
2 W 1 0 0 2 000000a5 00000000
2 W 1 1 0 2 0000beef 00000000
2 W 1 0 0 1 0000007c 00000000
2 R 1 2 0 0 00000000 beef7c11
2 R 1 0 0 3 00000000 ffffffbe
2 R 1 1 1 0 00000000 00007c11
2 W 0 2 0 0 80f08002 00000000
2 R 0 2 0 0 00000000 80f08000
2 R 0 0 0 1 00000000 ffffff80
2 R 0 1 0 2 00000000 ffff80f0
2 R 0 1 1 2 00000000 000080f0
3 W 0 2 0 0 00000001 00000000
3 W 1 2 0 0 12345678 00000000
3 W 2 2 0 0 00000000 00000000
3 W 1 2 0 0 cafef00d 00000000
3 W 2 2 0 0 00000000 00000000
3 P 3 2 0 0 00000000 00000000
3 R 4 2 0 0 00000000 00000000
3 W 1 2 0 0 0f1e2d3c 00000000
3 W 2 2 0 0 00000000 00000000
3 P 3 2 0 0 00000000 00000000
3 R 4 2 0 0 00000000 12345678
4 W 0 2 0 0 00000000 00000000
4 W 1 2 0 0 01020304 00000000
4 W 2 2 0 0 00000000 00000000
4 W 2 2 0 0 00000000 00000000
4 W 1 2 0 0 05060708 00000000
4 W 2 2 0 0 00000000 00000000
4 W 2 2 0 0 00000000 00000000
4 R 3 2 0 0 00000000 00000140
4 W 1 2 0 0 11223344 00000000
4 S 2 2 0 0 00000000 00000000
4 W 0 2 0 0 00000001 00000000
4 P 3 2 0 0 00000000 00000000
4 R 4 2 0 0 00000000 05060708
5 W 0 2 0 0 00000000 00000000
5 W 2 2 0 0 00000000 00000000
5 W 2 2 0 0 00000000 00000000
5 R 3 2 0 0 00000000 00000020
5 W 0 2 0 0 00000002 00000000
5 R 3 2 0 0 00000000 00000000
5 W 0 2 0 0 00000001 00000000
5 P 3 2 0 0 00000000 00000000
5 R 4 2 0 0 00000000 05060708

// ==== vlog.f ====
design/fcb_pkg.sv
design/cfg_fifo.sv
design/cfg_chain.sv
design/chain_shifter.sv
design/fcb_regs.sv
design/mem_master.sv
design/cfg_subsys_top.sv
bench/tb_cfg_subsys.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --timescale 1ns/1ps
TOP      = tb_cfg_subsys
FILELIST = vlog.f

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(TOOL) --lint-only -Wall $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/tb_cfg_subsys.sv ====
`default_nettype none

module tb_cfg_subsys
	import fcb_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD      = 4;
	localparam int          RESET_CYCLES    = 8;
	localparam int          DONE_LIMIT      = 64;
	localparam int          STALL_CYCLES    = 40;
	localparam int          POLL_LIMIT      = 400;
	localparam int          CYCLES_PER_LINE = 200;
	localparam int          MARGIN_CYCLES   = 1000;
	localparam logic [31:0] SEED            = 32'hff97_4170;

	// One line of the data file.
	typedef struct packed {
		int          test;
		int          line;
		logic [7:0]  op;
		logic [2:0]  adr;
		mem_size_e   size;
		logic        uns;
		logic [1:0]  lane;
		logic [31:0] data;
		logic [31:0] exp;
	} step_t;

	logic       clk;
	logic       arst_n;
	mem_req_t   req;
	logic [1:0] lane;
	logic       req_ready;
	mem_rsp_t   rsp;
	logic       busy;

	step_t steps[$];
	int    n_steps;
	int    errors;
	int    checks;
	int    test_checks;
	int    test_errors;
	int    tests_run;
	int    tests_failed;

	cfg_subsys_top u_cfg_subsys_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.lane      (lane),
		.req_ready (req_ready),
		.rsp       (rsp),
		.busy      (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic count_check();
		checks++;
		test_checks++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic report_mismatch(input step_t s, input logic [31:0] got);
		$display("MISMATCH at %0t ns: test %0d line %0d, load of reg %0d gave %h, expected %h",
			$time, s.test, s.line, s.adr, got, s.exp);
		errors++;
		test_errors++;
	endtask

	// Waits for req_ready, idles a few random cycles, then holds valid for one cycle.
	task automatic send(input logic is_wr, input logic [2:0] a, input mem_size_e sz,
			input logic u, input logic [1:0] ln, input logic [31:0] d);
		int gap;
		gap = int'($urandom % 32'd4);
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		req  <= '{valid: 1'b1, we: is_wr, addr: a, wdata: d, size: sz, uns: u};
		lane <= ln;
		@(posedge clk);
		req.valid <= 1'b0;
	endtask

	task automatic wait_done(input int limit, output logic seen, output logic [31:0] data);
		int n;
		seen = 1'b0;
		data = '0;
		n = 0;
		while (!seen && n < limit)
		begin
			@(negedge clk);
			if (rsp.done)
			begin
				seen = 1'b1;
				data = rsp.rdata;
			end
			n++;
		end
	endtask

	task automatic bus_access(input logic is_wr, input logic [2:0] a, input mem_size_e sz,
			input logic u, input logic [1:0] ln, input logic [31:0] d, input int limit,
			output logic seen, output logic [31:0] data);
		send(is_wr, a, sz, u, ln, d);
		wait_done(limit, seen, data);
	endtask

	// Idle means busy clear and FIFO level zero.
	task automatic poll_idle(input step_t s);
		logic        seen;
		logic        idle;
		logic [31:0] st;
		int          n;
		idle = 1'b0;
		seen = 1'b1;
		n = 0;
		while (!idle && seen && n < POLL_LIMIT)
		begin
			bus_access(1'b0, REG_STATUS, SIZE_WORD, 1'b0, 2'd0, '0, DONE_LIMIT, seen, st);
			idle = seen && !st[STAT_BUSY] && st[STAT_LEVEL +: LEVEL_W] == '0;
			n++;
		end
		count_check();
		if (!seen)
			report_failure($sformatf("test %0d line %0d: status read got no response",
				s.test, s.line));
		else if (!idle)
			report_failure($sformatf("test %0d line %0d: still busy after %0d status reads",
				s.test, s.line, n));
	endtask

	// Push into a full FIFO must hold until the shifter drains one word.
	task automatic stalled_push(input step_t s);
		logic        seen;
		logic [31:0] data;
		send(1'b1, s.adr, s.size, s.uns, s.lane, s.data);
		wait_done(STALL_CYCLES, seen, data);
		count_check();
		if (seen)
			report_failure($sformatf("test %0d line %0d: push finished while the FIFO was full",
				s.test, s.line));
		else
		begin
			force u_cfg_subsys_top.enable = 1'b1;   // Side path, the bus is held.
			wait_done(DONE_LIMIT, seen, data);
			release u_cfg_subsys_top.enable;
			count_check();
			if (!seen)
				report_failure($sformatf("test %0d line %0d: held push never finished",
					s.test, s.line));
		end
	endtask

	task automatic run_step(input step_t s);
		logic        seen;
		logic [31:0] data;
		case (s.op)
			"W":
			begin
				bus_access(1'b1, s.adr, s.size, s.uns, s.lane, s.data, DONE_LIMIT, seen, data);
				count_check();
				if (!seen)
					report_failure($sformatf("test %0d line %0d: store got no response",
						s.test, s.line));
			end
			"R":
			begin
				bus_access(1'b0, s.adr, s.size, s.uns, s.lane, s.data, DONE_LIMIT, seen, data);
				count_check();
				if (!seen)
					report_failure($sformatf("test %0d line %0d: load got no response",
						s.test, s.line));
				else if (data !== s.exp)
					report_mismatch(s, data);
			end
			"P":     poll_idle(s);
			"S":     stalled_push(s);
			default: report_failure($sformatf("line %0d: unknown op code", s.line));
		endcase
	endtask

	task automatic close_test(input int id);
		$display("test %0d finished: %0d checks, %0d errors", id, test_checks, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial
	begin
		int          fd;
		int          cnt;
		int          line_no;
		int          t;
		int          sz;
		int          u;
		int          ln;
		int          cur;
		string       text;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		arst_n       = 1'b0;
		req          = '0;
		lane         = '0;
		n_steps      = 0;
		errors       = 0;
		checks       = 0;
		test_checks  = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		line_no      = 0;
		void'($urandom(SEED));

		fd = $fopen("bench/cfg_testdata.txt", "r");
		if (fd == 0)
			report_failure("cannot open bench/cfg_testdata.txt");
		else
		begin
			while (!$feof(fd))
			begin
				text = "";
				cnt = $fgets(text, fd);
				line_no++;
				if (cnt > 0 && text.len() > 0 && text[0] != "#")
				begin
					cnt = $sscanf(text, "%d %s %h %d %d %d %h %h", t, op, a, sz, u, ln, d, e);
					if (cnt == 8)
						steps.push_back('{test: t, line: line_no, op: op, adr: a[2:0],
							size: mem_size_e'(sz[1:0]), uns: u[0], lane: ln[1:0],
							data: d, exp: e});
				end
			end
			$fclose(fd);
			if (steps.size() == 0)
				report_failure("the test data file holds no steps");
		end
		n_steps = steps.size();

		if (n_steps > 0)
		begin
			repeat (RESET_CYCLES) @(posedge clk);
			arst_n <= 1'b1;
			@(negedge clk);
			count_check();
			if (!req_ready || busy || rsp.done)
				report_failure("outputs after reset are not idle, req_ready should be high");
			cur = steps[0].test;
			foreach (steps[i])
			begin
				if (steps[i].test != cur)
				begin
					close_test(cur);
					cur = steps[i].test;
				end
				run_step(steps[i]);
			end
			close_test(cur);
		end

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Budget scales with the number of data lines.
	initial
	begin
		wait (n_steps > 0);
		#(CLK_PERIOD * (n_steps * CYCLES_PER_LINE + MARGIN_CYCLES));
		$display("Watchdog expired before all test steps finished");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/cfg_subsys_top.sv ====
`default_nettype none

module cfg_subsys_top
	import fcb_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire mem_req_t   req,
	input  wire logic [1:0] lane,
	output logic            req_ready,
	output mem_rsp_t        rsp,
	output logic            busy
);

	wb_m2s_t            wb_m2s;
	wb_s2m_t            wb_s2m;
	logic               push;
	logic [DATA_W-1:0]  push_data;
	logic               full;
	logic [LEVEL_W-1:0] level;
	logic               flush;
	logic               enable;
	logic               pop;
	logic [DATA_W-1:0]  pop_data;
	logic               empty;
	logic               chain_head;
	logic               prog_clk;
	logic               chain_tail;
	logic [DATA_W-1:0]  rb_word;
	logic               rb_valid;

	mem_master u_mem_master (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.rsp       (rsp),
		.req_ready (req_ready),
		.lane      (lane),
		.wbo       (wb_m2s),
		.wbi       (wb_s2m)
	);

	fcb_regs u_fcb_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.wbi       (wb_m2s),
		.wbo       (wb_s2m),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.level     (level),
		.flush     (flush),
		.enable    (enable),
		.busy      (busy),
		.rb_word   (rb_word),
		.rb_valid  (rb_valid)
	);

	cfg_fifo u_cfg_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty),
		.level     (level)
	);

	chain_shifter u_chain_shifter (
		.clk        (clk),
		.arst_n     (arst_n),
		.enable     (enable),
		.empty      (empty),
		.pop        (pop),
		.pop_data   (pop_data),
		.chain_head (chain_head),
		.prog_clk   (prog_clk),
		.chain_tail (chain_tail),
		.busy       (busy),
		.rb_word    (rb_word),
		.rb_valid   (rb_valid)
	);

	cfg_chain u_cfg_chain (
		.prog_clk   (prog_clk),
		.arst_n     (arst_n),
		.chain_head (chain_head),
		.chain_tail (chain_tail)
	);

endmodule

`default_nettype wire

// ==== design/mem_master.sv ====
`default_nettype none

module mem_master
	import fcb_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    arst_n,
	input  wire mem_req_t req,
	output mem_rsp_t     rsp,
	output logic         req_ready,
	input  wire logic [1:0] lane,
	output wb_m2s_t      wbo,
	input  wire wb_s2m_t wbi
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_RESP
	} state_e;

	state_e            state_q;
	logic              we_q;
	logic [ADDR_W-1:0] adr_q;
	logic [SEL_W-1:0]  sel_q;
	logic [DATA_W-1:0] wdat_q;
	mem_size_e         size_q;
	logic              uns_q;
	logic [1:0]        lane_q;
	logic [DATA_W-1:0] rdata_q;
	logic [SEL_W-1:0]  sel_d;
	logic [DATA_W-1:0] wdat_d;
	logic              capture;

	// Pick the returned lane and extend it to a full word.
	function automatic logic [DATA_W-1:0] extend(input logic [DATA_W-1:0] d,
			input logic [1:0] ln, input mem_size_e sz, input logic u);
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] h;
		b = d >> {ln, 3'b000};
		h = d >> {ln[1], 4'b0000};
		case (sz)
			SIZE_BYTE: extend = u ? {{(DATA_W-8){1'b0}}, b[7:0]} : {{(DATA_W-8){b[7]}}, b[7:0]};
			SIZE_HALF: extend = u ? {{(DATA_W-16){1'b0}}, h[15:0]} : {{(DATA_W-16){h[15]}}, h[15:0]};
			default:   extend = d;
		endcase
	endfunction

	assign capture   = req.valid && state_q == ST_IDLE;
	assign req_ready = state_q == ST_IDLE;

	// Byte enables and replicated store data.
	always_comb
	begin
		case (req.size)
			SIZE_BYTE:
			begin
				sel_d  = 4'b0001 << lane;
				wdat_d = {4{req.wdata[7:0]}};
			end
			SIZE_HALF:
			begin
				sel_d  = 4'b0011 << {lane[1], 1'b0};
				wdat_d = {2{req.wdata[15:0]}};
			end
			default:
			begin
				sel_d  = 4'b1111;
				wdat_d = req.wdata;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state_q <= ST_IDLE;
		else
		begin
			case (state_q)
				ST_IDLE: if (capture) state_q <= ST_BUS;
				ST_BUS:  if (wbi.ack) state_q <= ST_RESP;
				default: state_q <= ST_IDLE;   // One done cycle.
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			we_q   <= req.we;
			adr_q  <= req.addr;
			sel_q  <= sel_d;
			wdat_q <= wdat_d;
			size_q <= req.size;
			uns_q  <= req.uns;
			lane_q <= lane;
		end
		if (state_q == ST_BUS && wbi.ack)
			rdata_q <= extend(wbi.dat, lane_q, size_q, uns_q);
	end

	assign wbo = '{cyc: state_q == ST_BUS, stb: state_q == ST_BUS, we: we_q,
		adr: adr_q, sel: sel_q, dat: wdat_q};
	assign rsp = '{done: state_q == ST_RESP, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== design/fcb_regs.sv ====
`default_nettype none

module fcb_regs
	import fcb_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire wb_m2s_t            wbi,
	output wb_s2m_t                 wbo,
	output logic                    push,
	output logic [DATA_W-1:0]       push_data,
	input  wire logic               full,
	input  wire logic [LEVEL_W-1:0] level,
	output logic                    flush,
	output logic                    enable,
	input  wire logic               busy,
	input  wire logic [DATA_W-1:0]  rb_word,
	input  wire logic               rb_valid
);

	logic              ack_q;
	logic [DATA_W-1:0] dat_q;
	logic [DATA_W-1:0] stage_q;
	logic [DATA_W-1:0] rb_q;
	logic [DATA_W-1:0] rd_data;
	fcb_word_u         ctrl_q;
	fcb_word_u         ctrl_wr;
	logic              flush_q;
	logic              access;
	logic              wr;
	logic              push_wr;
	logic              stall;

	function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] nw, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] m;
		m = old;
		for (int i = 0; i < SEL_W; i++)
			if (sel[i])
				m[8*i +: 8] = nw[8*i +: 8];
		return m;
	endfunction

	assign access  = wbi.cyc && wbi.stb && !ack_q;
	assign wr      = access && wbi.we;
	assign push_wr = wr && wbi.adr == REG_PUSH;
	assign stall   = push_wr && full;   // Hold ack until an entry frees.

	assign push      = push_wr && !full;
	assign push_data = stage_q;
	assign flush     = flush_q;
	assign enable    = ctrl_q.ctrl.enable;
	assign ctrl_wr.raw = merge(ctrl_q.raw, wbi.dat, wbi.sel);

	always_comb
	begin
		rd_data = '0;
		case (wbi.adr)
			REG_CTRL:     rd_data = ctrl_q.raw;
			REG_STAGE:    rd_data = stage_q;
			REG_STATUS:
			begin
				rd_data[STAT_BUSY]             = busy;
				rd_data[STAT_LEVEL +: LEVEL_W] = level;
				rd_data[STAT_FULL]             = full;
			end
			REG_READBACK: rd_data = rb_q;
			default:      rd_data = '0;   // Push register and holes.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ack_q   <= 1'b0;
			flush_q <= 1'b0;
			ctrl_q  <= '0;
			stage_q <= '0;
			rb_q    <= '0;
		end
		else
		begin
			ack_q   <= access && !stall;
			flush_q <= 1'b0;
			if (wr && wbi.adr == REG_CTRL)
			begin
				ctrl_q            <= ctrl_wr;
				ctrl_q.ctrl.flush <= 1'b0;   // Flush is a one-cycle strobe.
				flush_q           <= ctrl_wr.ctrl.flush;
			end
			if (wr && wbi.adr == REG_STAGE)
				stage_q <= merge(stage_q, wbi.dat, wbi.sel);
			if (rb_valid)
				rb_q <= rb_word;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access && !stall)
			dat_q <= rd_data;
	end

	assign wbo = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== design/chain_shifter.sv ====
`default_nettype none

module chain_shifter
	import fcb_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              enable,
	input  wire logic              empty,
	output logic                   pop,
	input  wire logic [DATA_W-1:0] pop_data,
	output logic                   chain_head,
	output logic                   prog_clk,
	input  wire logic              chain_tail,
	output logic                   busy,
	output logic [DATA_W-1:0]      rb_word,
	output logic                   rb_valid
);

	typedef enum logic {
		ST_IDLE,
		ST_SHIFT
	} state_e;

	state_e            state_q;
	logic              phase_q;   // 0 sets up the bit, 1 drives prog_clk high.
	logic [BIT_W-1:0]  bit_cnt_q;
	logic              rb_valid_q;
	logic [DATA_W-1:0] sh_q;
	logic [DATA_W-1:0] cap_q;
	logic              last_bit;

	assign pop      = state_q == ST_IDLE && enable && !empty;
	assign last_bit = bit_cnt_q == BIT_W'(DATA_W - 1);
	assign busy     = state_q == ST_SHIFT;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q    <= ST_IDLE;
			phase_q    <= 1'b0;
			bit_cnt_q  <= '0;
			rb_valid_q <= 1'b0;
		end
		else
		begin
			rb_valid_q <= 1'b0;
			case (state_q)
				ST_IDLE:
				begin
					if (pop)
					begin
						state_q   <= ST_SHIFT;
						phase_q   <= 1'b0;
						bit_cnt_q <= '0;
					end
				end
				default:
				begin
					phase_q <= !phase_q;
					if (phase_q)
					begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (last_bit)
						begin
							state_q    <= ST_IDLE;
							rb_valid_q <= 1'b1;   // All tail bits are in.
						end
					end
				end
			endcase
		end
	end

	// The tail bit is taken before the chain edge moves it out.
	always_ff @(posedge clk)
	begin
		if (pop)
			sh_q <= pop_data;
		else if (state_q == ST_SHIFT && phase_q)
			sh_q <= sh_q >> 1;
		if (state_q == ST_SHIFT && !phase_q)
			cap_q <= {chain_tail, cap_q[DATA_W-1:1]};
	end

	assign chain_head = sh_q[0];
	assign prog_clk   = phase_q;
	assign rb_word    = cap_q;
	assign rb_valid   = rb_valid_q;

endmodule

`default_nettype wire

// ==== design/cfg_chain.sv ====
`default_nettype none

module cfg_chain
	import fcb_pkg::*;
(
	input  wire logic prog_clk,
	input  wire logic arst_n,
	input  wire logic chain_head,
	output logic      chain_tail
);

	logic [CHAIN_W-1:0] chain_q;

	// Head enters at the top, bit 0 leaves first.
	always_ff @(posedge prog_clk or negedge arst_n)
	begin
		if (!arst_n)
			chain_q <= '0;
		else
			chain_q <= {chain_head, chain_q[CHAIN_W-1:1]};
	end

	assign chain_tail = chain_q[0];

endmodule

`default_nettype wire

// ==== design/cfg_fifo.sv ====
`default_nettype none

module cfg_fifo
	import fcb_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              flush,
	input  wire logic              push,
	input  wire logic [DATA_W-1:0] push_data,
	input  wire logic              pop,
	output logic [DATA_W-1:0]      pop_data,
	output logic                   full,
	output logic                   empty,
	output logic [LEVEL_W-1:0]     level
);

	logic [DATA_W-1:0]  mem_q [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   rd_ptr_q;
	logic [LEVEL_W-1:0] count_q;
	logic               do_push;
	logic               do_pop;

	assign full     = count_q == LEVEL_W'(FIFO_DEPTH);
	assign empty    = count_q == '0;
	assign level    = count_q;
	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign pop_data = mem_q[rd_ptr_q];   // Show-ahead read.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else if (flush)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at the depth.
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + LEVEL_W'(do_push) - LEVEL_W'(do_pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem_q[wr_ptr_q] <= push_data;
	end

endmodule

`default_nettype wire

// ==== design/fcb_pkg.sv ====
`default_nettype none

package fcb_pkg;

	localparam int DATA_W      = 32;
	localparam int SEL_W       = DATA_W / 8;
	localparam int ADDR_W      = 3;
	localparam int CHAIN_WORDS = 2;
	localparam int CHAIN_W     = CHAIN_WORDS * DATA_W;
	localparam int FIFO_DEPTH  = 4;
	localparam int PTR_W       = $clog2(FIFO_DEPTH);
	localparam int LEVEL_W     = $clog2(FIFO_DEPTH + 1);
	localparam int BIT_W       = $clog2(DATA_W);

	// Register map, word addresses.
	localparam logic [ADDR_W-1:0] REG_CTRL     = 3'd0;
	localparam logic [ADDR_W-1:0] REG_STAGE    = 3'd1;
	localparam logic [ADDR_W-1:0] REG_PUSH     = 3'd2;
	localparam logic [ADDR_W-1:0] REG_STATUS   = 3'd3;
	localparam logic [ADDR_W-1:0] REG_READBACK = 3'd4;

	// Status word bit positions.
	localparam int STAT_BUSY  = 0;
	localparam int STAT_LEVEL = 4;
	localparam int STAT_FULL  = 8;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef struct packed {
		logic              valid;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		mem_size_e         size;
		logic              uns;   // Zero-extend loads.
	} mem_req_t;

	typedef struct packed {
		logic              done;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] dat;
	} wb_m2s_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_s2m_t;

	// Enable sits in bit 0, flush in bit 1.
	typedef struct packed {
		logic [29:0] spare;
		logic        flush;
		logic        enable;
	} fcb_ctrl_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		fcb_ctrl_t         ctrl;
	} fcb_word_u;

endpackage

`default_nettype wire
